// File: design/alu.sv
`timescale 1ns/1ps
`include "intexu_cfg.svh"

module alu
    import intexu_pkg::*;
(
    input  issue_t                  issue,
    output logic [`INTEXU_XLEN-1:0] result
);

    // operands after word-mode conditioning
    logic [`INTEXU_XLEN-1:0] op_a;
    logic [`INTEXU_XLEN-1:0] op_b;
    logic [5:0]              shamt;
    logic                    less;
    logic [`INTEXU_XLEN-1:0] raw;

    // operand select
    always_comb begin
        op_a = issue.src1;
        op_b = issue.is_imm ? issue.imm : issue.src2;
        if (issue.is_word) begin
            // srl needs zeros above bit 31 so they never shift down
            if (issue.alu_op == ALU_SRL) begin
                op_a = {{(`INTEXU_XLEN-32){1'b0}}, issue.src1[31:0]};
            end else begin
                op_a = {{(`INTEXU_XLEN-32){issue.src1[31]}}, issue.src1[31:0]};
            end
            // sign extended copy keeps signed and unsigned order for slt
            op_b = {{(`INTEXU_XLEN-32){op_b[31]}}, op_b[31:0]};
        end
    end

    // 6 bit shift amount, 5 in word mode
    assign shamt = issue.is_word ? {1'b0, op_b[4:0]} : op_b[5:0];

    // slt compare
    always_comb begin
        if (issue.is_unsigned) begin
            less = op_a < op_b;
        end else begin
            less = $signed(op_a) < $signed(op_b);
        end
    end

    always_comb begin
        case (issue.alu_op)
            ALU_ADD: begin
                raw = op_a + op_b;
            end
            ALU_SUB: begin
                raw = op_a - op_b;
            end
            ALU_AND: begin
                raw = op_a & op_b;
            end
            ALU_OR: begin
                raw = op_a | op_b;
            end
            ALU_XOR: begin
                raw = op_a ^ op_b;
            end
            ALU_SLL: begin
                raw = op_a << shamt;
            end
            ALU_SRL: begin
                raw = op_a >> shamt;
            end
            ALU_SRA: begin
                // op_a already sign extended in word mode
                raw = $unsigned($signed(op_a) >>> shamt);
            end
            ALU_SLT: begin
                raw = `INTEXU_XLEN'(less);
            end
            ALU_LUI: begin
                // decode already placed the upper immediate
                raw = issue.imm;
            end
            ALU_AUIPC: begin
                raw = issue.pc + issue.imm;
            end
            default: begin
                raw = '0;
            end
        endcase
    end

    // word ops keep low half, sign extended
    assign result = issue.is_word ? {{(`INTEXU_XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

// File: design/bju.sv
`timescale 1ns/1ps
`include "intexu_cfg.svh"

module bju
    import intexu_pkg::*;
(
    input  issue_t                  issue,
    output logic [`INTEXU_XLEN-1:0] result,
    output redirect_t               redirect,
    output bht_upd_t                bht_upd,
    output btb_upd_t                btb_upd
);

    logic                            eq;
    logic                            lt;
    logic                            taken;
    logic                            is_jump;
    logic                            is_branch;
    logic                            tgt_miss;
    logic [`INTEXU_XLEN-1:0]         link;
    logic [`INTEXU_XLEN-1:0]         pc_tgt;
    logic [`INTEXU_XLEN-1:0]         jalr_sum;
    logic [`INTEXU_XLEN-1:0]         target;
    logic [`INTEXU_BHT_INDEX_W-1:0]  set_index;

    // op class
    assign is_jump   = (issue.bju_op == BJU_JAL) || (issue.bju_op == BJU_JALR);
    assign is_branch = issue.bju_op inside {BJU_BEQ, BJU_BNE, BJU_BLT, BJU_BGE};

    // compare for conditional branches
    assign eq = issue.src1 == issue.src2;

    always_comb begin
        if (issue.is_unsigned) begin
            lt = issue.src1 < issue.src2;
        end else begin
            lt = $signed(issue.src1) < $signed(issue.src2);
        end
    end

    // resolve direction
    always_comb begin
        case (issue.bju_op)
            BJU_BEQ: begin
                taken = eq;
            end
            BJU_BNE: begin
                taken = !eq;
            end
            BJU_BLT: begin
                taken = lt;
            end
            BJU_BGE: begin
                taken = !lt;
            end
            BJU_JAL, BJU_JALR: begin
                taken = 1'b1;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // targets
    assign link     = issue.pc + `INTEXU_XLEN'd4;
    assign pc_tgt   = issue.pc + issue.imm;
    assign jalr_sum = issue.src1 + issue.imm;
    // jalr drops bit 0 of the sum
    assign target   = (issue.bju_op == BJU_JALR) ?
                      {jalr_sum[`INTEXU_XLEN-1:1], 1'b0} : pc_tgt;

    // link value only for jumps
    assign result = is_jump ? link : '0;

    // btb keeps only the low target bits
    assign tgt_miss  = target[`INTEXU_TGT_W-1:0] != issue.predict_target;
    assign set_index = issue.pc[`INTEXU_BHT_INDEX_W+1:2];

    // wrong direction, or taken to the wrong place
    assign redirect.valid  = (taken != issue.predict_taken) || (taken && tgt_miss);
    // fall through when the op was predicted taken but is not
    assign redirect.target = taken ? target : link;

    // counters train on conditional branches only
    assign bht_upd.valid = is_branch;
    assign bht_upd.index = set_index;
    assign bht_upd.inc   = is_branch && taken;
    assign bht_upd.dec   = is_branch && !taken;

    // install target when btb missed or held a stale one
    assign btb_upd.valid  = taken && (!issue.predict_taken || tgt_miss);
    assign btb_upd.index  = set_index;
    assign btb_upd.target = target[`INTEXU_TGT_W-1:0];

    // a jump always leaves for its computed target
    // and a not taken prediction always redirects and installs
    always_comb begin
        if (is_jump) begin
            assert (redirect.target == target &&
                    (issue.predict_taken || (redirect.valid && btb_upd.valid)))
                else $error("bju: jump resolved as not taken");
        end
    end

endmodule

// File: design/intblock.sv
`timescale 1ns/1ps
`include "intexu_cfg.svh"

module intblock
    import intexu_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  issue_t                  issue,
    input  logic                    flush_valid,
    input  logic [`INTEXU_ID_W-1:0] flush_id,
    output wb_t                     wb,
    output redirect_t               redirect,
    output bht_upd_t                bht_upd,
    output btb_upd_t                btb_upd,
    output logic [`INTEXU_XLEN-1:0] ex_byp_result
);

    // unit results before merge
    logic [`INTEXU_XLEN-1:0] alu_result;
    logic [`INTEXU_XLEN-1:0] bju_result;
    redirect_t               bju_redirect;
    bht_upd_t                bju_bht;
    btb_upd_t                bju_btb;

    // both units see every op
    alu u_alu (
        .issue  (issue),
        .result (alu_result)
    );

    bju u_bju (
        .issue    (issue),
        .result   (bju_result),
        .redirect (bju_redirect),
        .bht_upd  (bju_bht),
        .btb_upd  (bju_btb)
    );

    // select, flush and register
    result_merge u_merge (
        .clock         (clock),
        .rst_n         (rst_n),
        .issue         (issue),
        .alu_result    (alu_result),
        .bju_result    (bju_result),
        .bju_redirect  (bju_redirect),
        .bju_bht       (bju_bht),
        .bju_btb       (bju_btb),
        .flush_valid   (flush_valid),
        .flush_id      (flush_id),
        .wb            (wb),
        .redirect      (redirect),
        .bht_upd       (bht_upd),
        .btb_upd       (btb_upd),
        .ex_byp_result (ex_byp_result)
    );

endmodule

// File: design/intexu_pkg.sv
`include "intexu_cfg.svh"

package intexu_pkg;

    // which execution unit an op was issued to
    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,
        UNIT_ALU  = 2'd1,
        UNIT_BJU  = 2'd2
    } unit_e;

    // alu opcodes
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_LUI   = 4'd9,
        ALU_AUIPC = 4'd10
    } alu_op_e;

    // branch and jump opcodes
    typedef enum logic [2:0] {
        BJU_BEQ  = 3'd0,
        BJU_BNE  = 3'd1,
        BJU_BLT  = 3'd2,
        BJU_BGE  = 3'd3,
        BJU_JAL  = 3'd4,
        BJU_JALR = 3'd5
    } bju_op_e;

    // one issued micro-op
    typedef struct packed {
        logic                           valid;
        logic [`INTEXU_XLEN-1:0]        pc;
        logic [`INTEXU_ID_W-1:0]        id;
        logic [`INTEXU_PREG_W-1:0]      prd;
        logic                           need_to_wb;
        logic [`INTEXU_XLEN-1:0]        src1;
        logic [`INTEXU_XLEN-1:0]        src2;
        logic [`INTEXU_XLEN-1:0]        imm;
        logic                           is_imm;
        logic                           is_word;
        logic                           is_unsigned;
        unit_e                          unit;
        alu_op_e                        alu_op;
        bju_op_e                        bju_op;
        logic                           predict_taken;
        logic [`INTEXU_TGT_W-1:0]       predict_target;
    } issue_t;

    // writeback towards the wb pipe register
    typedef struct packed {
        logic                           valid;
        logic [`INTEXU_XLEN-1:0]        pc;
        logic [`INTEXU_ID_W-1:0]        id;
        logic [`INTEXU_PREG_W-1:0]      prd;
        logic                           need_to_wb;
        logic [`INTEXU_XLEN-1:0]        result;
    } wb_t;

    typedef struct packed {
        logic                           valid;
        logic [`INTEXU_XLEN-1:0]        target;
    } redirect_t;

    // counter bump for one bht set
    typedef struct packed {
        logic                           valid;
        logic [`INTEXU_BHT_INDEX_W-1:0] index;
        logic                           inc;
        logic                           dec;
    } bht_upd_t;

    typedef struct packed {
        logic                           valid;
        logic [`INTEXU_BHT_INDEX_W-1:0] index;
        logic [`INTEXU_TGT_W-1:0]       target;
    } btb_upd_t;

endpackage

// File: design/result_merge.sv
`timescale 1ns/1ps
`include "intexu_cfg.svh"

module result_merge
    import intexu_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  issue_t                  issue,
    input  logic [`INTEXU_XLEN-1:0] alu_result,
    input  logic [`INTEXU_XLEN-1:0] bju_result,
    input  redirect_t               bju_redirect,
    input  bht_upd_t                bju_bht,
    input  btb_upd_t                bju_btb,
    input  logic                    flush_valid,
    input  logic [`INTEXU_ID_W-1:0] flush_id,
    output wb_t                     wb,
    output redirect_t               redirect,
    output bht_upd_t                bht_upd,
    output btb_upd_t                btb_upd,
    output logic [`INTEXU_XLEN-1:0] ex_byp_result
);

    logic                    same_wrap;
    logic                    flush_older;
    logic                    kill;
    logic                    live;
    logic                    bju_live;
    logic [`INTEXU_XLEN-1:0] sel_result;

    // age compare on ids with wrap flag in the msb
    assign same_wrap = flush_id[`INTEXU_ID_W-1] == issue.id[`INTEXU_ID_W-1];
    // wrapped flush is older when its low bits are not below ours
    assign flush_older = same_wrap ?
        (flush_id[`INTEXU_ID_W-2:0] <  issue.id[`INTEXU_ID_W-2:0]) :
        (flush_id[`INTEXU_ID_W-2:0] >= issue.id[`INTEXU_ID_W-2:0]);
    assign kill = flush_valid && flush_older;

    assign live     = issue.valid && !kill;
    assign bju_live = live && (issue.unit == UNIT_BJU);

    // result by unit
    always_comb begin
        case (issue.unit)
            UNIT_ALU: sel_result = alu_result;
            UNIT_BJU: sel_result = bju_result;
            default:  sel_result = `INTEXU_BYP_FILL;
        endcase
    end

    // bypass to decode in the issue cycle
    assign ex_byp_result = sel_result;

    always_ff @(posedge clock) begin
        // payload follows issue every cycle
        wb.pc           <= issue.pc;
        wb.id           <= issue.id;
        wb.prd          <= issue.prd;
        wb.need_to_wb   <= issue.need_to_wb;
        wb.result       <= sel_result;
        redirect.target <= bju_redirect.target;
        bht_upd.index   <= bju_bht.index;
        bht_upd.inc     <= bju_bht.inc;
        bht_upd.dec     <= bju_bht.dec;
        btb_upd.index   <= bju_btb.index;
        btb_upd.target  <= bju_btb.target;
        if (!rst_n) begin
            wb.valid       <= 1'b0;
            redirect.valid <= 1'b0;
            bht_upd.valid  <= 1'b0;
            btb_upd.valid  <= 1'b0;
        end else begin
            wb.valid       <= live;
            // branch side effects only for surviving bju ops
            redirect.valid <= bju_live && bju_redirect.valid;
            bht_upd.valid  <= bju_live && bju_bht.valid;
            btb_upd.valid  <= bju_live && bju_btb.valid;
        end
    end

    // redirect travels with its own writeback and always trains the predictor
    assert property (@(posedge clock) disable iff (!rst_n)
        redirect.valid |-> wb.valid && (bht_upd.valid || btb_upd.valid));

    // issue never sends a valid op without a unit
    assert property (@(posedge clock) disable iff (!rst_n)
        issue.valid |-> issue.unit != UNIT_NONE);

endmodule

// File: include/intexu_cfg.svh
`ifndef INTEXU_CFG_SVH
`define INTEXU_CFG_SVH

// operand, result and pc width
`define INTEXU_XLEN 64

// instruction id width
// msb is the wrap flag used for age compare
`define INTEXU_ID_W 8

// physical destination tag
`define INTEXU_PREG_W 6

// set index into bht and btb
// taken from pc starting at bit 2
`define INTEXU_BHT_INDEX_W 9

// predicted target as the btb holds it
`define INTEXU_TGT_W 32

// bypass value when no unit owns the op
`define INTEXU_BYP_FILL 64'h0000_0000_dead_beef

`endif

// File: run.sh
#!/bin/sh
# build and run the intblock testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_intblock \
    -f verilog.f \
    -o sim_intblock
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_intblock
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi
exit 0

// File: test/intblock_stimulus.txt
// unit op flags id flush pc src1 src2 imm ptgt valids result rtgt btgt
// flags from bit 0 are is_imm is_word is_unsigned predict_taken valid, flush bit 8 is valid
// valids from bit 0 are wb redirect bht inc dec btb, rtgt and btgt matter only when raised
// alu ops
1 0 10 01 000 1000 5 7 0 0 01 c 0 0
1 0 11 02 000 1004 64 0 ffffffffffffff9c 0 01 0 0 0
1 0 12 03 000 1008 7fffffff 1 0 0 01 ffffffff80000000 0 0
1 1 10 04 000 100c 3 5 0 0 01 fffffffffffffffe 0 0
1 1 12 05 000 1010 100000000 1 0 0 01 ffffffffffffffff 0 0
1 2 10 06 000 1014 f0f0 ff00 0 0 01 f000 0 0
1 3 11 07 000 1018 f0 0 f 0 01 ff 0 0
1 4 10 08 000 101c aaaa ffff 0 0 01 5555 0 0
1 5 10 09 000 1020 1 3f 0 0 01 8000000000000000 0 0
1 5 12 0a 000 1024 1 3f 0 0 01 ffffffff80000000 0 0
1 6 10 0b 000 1028 8000000000000000 3c 0 0 01 8 0 0
1 6 12 0c 000 102c ffffffff80000000 4 0 0 01 8000000 0 0
1 7 10 0d 000 1030 8000000000000000 3c 0 0 01 fffffffffffffff8 0 0
1 7 13 0e 000 1034 80000000 0 4 0 01 fffffffff8000000 0 0
1 8 10 0f 000 1038 ffffffffffffffff 1 0 0 01 1 0 0
1 8 14 10 000 103c ffffffffffffffff 1 0 0 01 0 0 0
1 8 15 11 000 1040 3 0 5 0 01 1 0 0
1 9 10 12 000 1044 0 0 12345000 0 01 12345000 0 0
1 a 10 13 000 2000 0 0 3000 0 01 5000 0 0
1 a 10 14 000 2000 0 0 fffffffffffff000 0 01 1000 0 0
// bubble with no unit, bypass shows the filler
0 0 00 15 000 0 0 0 0 0 00 deadbeef 0 0
// conditional branches
2 0 18 20 000 1100 5 5 40 1140 0d 0 0 0
2 0 10 21 000 1104 5 5 40 0 2f 0 1144 1144
2 1 18 22 000 1108 7 7 40 1148 17 0 110c 0
2 1 18 23 000 110c 1 2 20 1200 2f 0 112c 112c
2 2 18 24 000 1110 ffffffffffffffff 1 fffffffffffffff0 1100 0d 0 0 0
2 2 14 25 000 1114 ffffffffffffffff 1 fffffffffffffff0 0 15 0 0 0
2 3 18 26 000 1118 ffffffffffffffff 1 8 1120 17 0 111c 0
2 3 14 27 000 111c ffffffffffffffff 1 8 0 2f 0 1124 1124
2 0 10 2c 000 1210 1 2 40 0 15 0 0 0
// jumps, link value in result
2 4 18 28 000 1200 0 0 100 1300 01 1204 0 0
2 4 10 29 000 1204 0 0 100 0 23 1208 1304 1304
2 5 18 2a 000 1208 3001 0 4 3005 23 120c 3004 3004
2 5 18 2b 000 120c 4000 0 ffffffffffffffff 3ffe 01 1210 0 0
// flush age, same wrap then across the wrap
2 4 10 05 103 1300 0 0 40 0 00 1304 0 0
2 4 10 05 107 1304 0 0 40 0 23 1308 1344 1344
2 0 10 85 185 1308 5 5 40 0 2f 0 1348 1348
2 0 10 02 1fe 130c 5 5 40 0 00 0 0 0
2 1 18 fe 101 1310 7 7 40 1350 17 0 1314 0
1 0 10 81 17f 1314 1 2 0 0 00 3 0 0
1 0 10 05 003 1318 1 2 0 0 01 3 0 0
1 4 10 10 190 131c ff f0 0 0 00 f 0 0

// File: test/tb_intblock.sv
`timescale 1ns/1ps
`include "intexu_cfg.svh"

module tb_intblock
    import intexu_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    // words per vector in the stimulus file
    localparam int FIELDS     = 14;
    localparam int MAX_VEC    = 64;
    localparam int N_RAND     = 40;

    logic                    clock;
    logic                    rst_n;
    issue_t                  issue;
    logic                    flush_valid;
    logic [`INTEXU_ID_W-1:0] flush_id;
    wb_t                     wb;
    redirect_t               redirect;
    bht_upd_t                bht_upd;
    btb_upd_t                btb_upd;
    logic [`INTEXU_XLEN-1:0] ex_byp_result;

    // flat image of the stimulus file
    logic [63:0] stim [0:FIELDS*MAX_VEC-1];
    int          n_vec;
    logic        loaded;
    logic [31:0] rng;

    // op in flight, checked one edge later
    logic        pend;
    string       pend_name;
    issue_t      pend_issue;
    logic [63:0] pend_valids;
    logic [63:0] pend_result;
    logic [63:0] pend_rtgt;
    logic [63:0] pend_btgt;

    intblock uut (
        .clock         (clock),
        .rst_n         (rst_n),
        .issue         (issue),
        .flush_valid   (flush_valid),
        .flush_id      (flush_id),
        .wb            (wb),
        .redirect      (redirect),
        .bht_upd       (bht_upd),
        .btb_upd       (btb_upd),
        .ex_byp_result (ex_byp_result)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD/2) clock = ~clock;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_word(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    // reference for random ops, built from the alu rules
    function automatic logic [63:0] alu_expect(input alu_op_e op, input logic [63:0] a,
                                               input logic [63:0] b, input logic word,
                                               input logic uns);
        logic [63:0] r;
        case (op)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a - b;
            ALU_XOR: r = a ^ b;
            default: r = uns ? 64'(a < b) : 64'($signed(a) < $signed(b));
        endcase
        // word ops keep the low half sign extended
        if (word) begin
            r = {{32{r[31]}}, r[31:0]};
        end
        return r;
    endfunction

    task automatic apply_vector(input int v);
        int b;
        b = v * FIELDS;
        issue                = '0;
        issue.unit           = unit_e'(stim[b][1:0]);
        issue.alu_op         = alu_op_e'(stim[b+1][3:0]);
        issue.bju_op         = bju_op_e'(stim[b+1][2:0]);
        // flag bits from bit 0: is_imm is_word is_unsigned predict_taken valid
        issue.is_imm         = stim[b+2][0];
        issue.is_word        = stim[b+2][1];
        issue.is_unsigned    = stim[b+2][2];
        issue.predict_taken  = stim[b+2][3];
        issue.valid          = stim[b+2][4];
        issue.id             = stim[b+3][`INTEXU_ID_W-1:0];
        flush_id             = stim[b+4][`INTEXU_ID_W-1:0];
        flush_valid          = stim[b+4][8];
        issue.pc             = stim[b+5];
        issue.src1           = stim[b+6];
        issue.src2           = stim[b+7];
        issue.imm            = stim[b+8];
        issue.predict_target = stim[b+9][`INTEXU_TGT_W-1:0];
        // tag varies per vector so each wb is told apart
        issue.prd            = v[`INTEXU_PREG_W-1:0];
        issue.need_to_wb     = v[0];
        pend_name   = $sformatf("vec%0d", v);
        pend_valids = stim[b+10];
        pend_result = stim[b+11];
        pend_rtgt   = stim[b+12];
        pend_btgt   = stim[b+13];
        pend_issue  = issue;
        pend        = 1'b1;
    endtask

    task automatic apply_random(input int n);
        logic [31:0] sel;
        logic [31:0] hi1;
        logic [31:0] lo1;
        logic [31:0] hi2;
        logic [31:0] lo2;
        alu_op_e     op;
        next_word(sel);
        next_word(hi1);
        next_word(lo1);
        next_word(hi2);
        next_word(lo2);
        case (sel[1:0])
            2'd0: op = ALU_ADD;
            2'd1: op = ALU_SUB;
            2'd2: op = ALU_XOR;
            default: op = ALU_SLT;
        endcase
        issue             = '0;
        issue.valid       = 1'b1;
        issue.unit        = UNIT_ALU;
        issue.alu_op      = op;
        issue.is_word     = sel[2] && (op != ALU_SLT);
        issue.is_unsigned = sel[3];
        issue.need_to_wb  = sel[4];
        issue.id          = sel[15:8];
        issue.prd         = sel[21:16];
        issue.pc          = {32'h0, sel};
        issue.src1        = {hi1, lo1};
        issue.src2        = {hi2, lo2};
        flush_valid       = 1'b0;
        flush_id          = '0;
        pend_name   = $sformatf("rand%0d", n);
        pend_valids = 64'h1;
        pend_result = alu_expect(op, issue.src1, issue.src2, issue.is_word, sel[3]);
        pend_rtgt   = '0;
        pend_btgt   = '0;
        pend_issue  = issue;
        pend        = 1'b1;
    endtask

    // registered outputs of the op issued one edge earlier
    task automatic check_pending();
        logic [63:0] idx;
        if (pend) begin
            // set index sits right above the two low pc bits
            idx = 64'(pend_issue.pc[`INTEXU_BHT_INDEX_W+1:2]);
            check_value({pend_name, ".wb_valid"}, 64'(pend_valids[0]), 64'(wb.valid));
            if (pend_valids[0]) begin
                check_value({pend_name, ".wb_result"}, pend_result, wb.result);
                check_value({pend_name, ".wb_pc"}, pend_issue.pc, wb.pc);
                check_value({pend_name, ".wb_id"}, 64'(pend_issue.id), 64'(wb.id));
                check_value({pend_name, ".wb_prd"}, 64'(pend_issue.prd), 64'(wb.prd));
                check_value({pend_name, ".wb_need"}, 64'(pend_issue.need_to_wb),
                            64'(wb.need_to_wb));
            end
            check_value({pend_name, ".redir_valid"}, 64'(pend_valids[1]),
                        64'(redirect.valid));
            if (pend_valids[1]) begin
                check_value({pend_name, ".redir_target"}, pend_rtgt, redirect.target);
            end
            check_value({pend_name, ".bht_valid"}, 64'(pend_valids[2]), 64'(bht_upd.valid));
            if (pend_valids[2]) begin
                check_value({pend_name, ".bht_inc"}, 64'(pend_valids[3]), 64'(bht_upd.inc));
                check_value({pend_name, ".bht_dec"}, 64'(pend_valids[4]), 64'(bht_upd.dec));
                check_value({pend_name, ".bht_index"}, idx, 64'(bht_upd.index));
            end
            check_value({pend_name, ".btb_valid"}, 64'(pend_valids[5]), 64'(btb_upd.valid));
            if (pend_valids[5]) begin
                check_value({pend_name, ".btb_target"}, pend_btgt, 64'(btb_upd.target));
                check_value({pend_name, ".btb_index"}, idx, 64'(btb_upd.index));
            end
        end
    endtask

    initial begin
        // live taken beq held through reset would raise every valid
        issue        = '0;
        issue.valid  = 1'b1;
        issue.unit   = UNIT_BJU;
        issue.bju_op = BJU_BEQ;
        flush_valid = 1'b0;
        flush_id    = '0;
        rst_n       = 1'b0;
        pend        = 1'b0;
        loaded      = 1'b0;
        rng         = 32'h563c4c40;
        n_vec       = 0;
        // all ones never shows up in a unit column
        for (int i = 0; i < FIELDS*MAX_VEC; i++) begin
            stim[i] = '1;
        end
        $readmemh("test/intblock_stimulus.txt", stim);
        while (n_vec < MAX_VEC && stim[n_vec*FIELDS] != '1) begin
            n_vec++;
        end
        if (n_vec == 0 || stim[n_vec*FIELDS-1] == '1) begin
            $display(">>> FAIL");
            $fatal(1, "stimulus file is missing or ends in a partial vector");
        end
        loaded = 1'b1;

        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        issue = '0;
        check_value("reset.wb_valid", 64'h0, 64'(wb.valid));
        check_value("reset.redir_valid", 64'h0, 64'(redirect.valid));
        check_value("reset.bht_valid", 64'h0, 64'(bht_upd.valid));
        check_value("reset.btb_valid", 64'h0, 64'(btb_upd.valid));

        // one op per cycle, back to back
        for (int v = 0; v < n_vec; v++) begin
            @(negedge clock);
            check_pending();
            apply_vector(v);
            @(posedge clock);
            check_value({pend_name, ".byp"}, pend_result, ex_byp_result);
        end
        for (int n = 0; n < N_RAND; n++) begin
            @(negedge clock);
            check_pending();
            apply_random(n);
            @(posedge clock);
            check_value({pend_name, ".byp"}, pend_result, ex_byp_result);
        end
        @(negedge clock);
        check_pending();
        $display(">>> PASS");
        $finish;
    end

    // one cycle per test plus slack for reset and drain
    initial begin
        wait (loaded === 1'b1);
        #((n_vec + N_RAND + 10) * CLK_PERIOD);
        $display(">>> FAIL");
        $fatal(1, "run timed out before all tests finished");
    end

endmodule

// File: verilog.f
+incdir+include
design/intexu_pkg.sv
design/alu.sv
design/bju.sv
design/result_merge.sv
design/intblock.sv
test/tb_intblock.sv
